// ==== design/bft_pkg.sv ====
// packet format of the butterfly fat tree.
package bft_pkg;

    // --------------------
    // field widths
    // --------------------
    localparam int PACKET_BITS  = 49;
    localparam int PAYLOAD_BITS = 32;
    localparam int LEAF_BITS    = 5;
    localparam int PORT_BITS    = 4;
    localparam int ADDR_BITS    = 7;

    // --------------------
    // packet layout from the msb down
    // --------------------
    // addr holds the sequence number in data packets
    // and the target port in configuration packets.
    typedef struct packed {
        logic                    vld;
        logic [LEAF_BITS-1:0]    leaf;
        logic [PORT_BITS-1:0]    port;
        logic [ADDR_BITS-1:0]    addr;
        logic [PAYLOAD_BITS-1:0] payload;
    } bft_packet_t;

endpackage

// ==== design/leaf_pkg.sv ====
// leaf side types.
package leaf_pkg;

    // --------------------
    // configuration
    // --------------------
    // opcode sits in payload bits 31..30 of a port 0 packet.
    typedef enum logic [1:0] {
        CFG_NOP       = 2'd0,
        CFG_SET_DEST  = 2'd1,
        CFG_CLEAR_OVF = 2'd2
    } cfg_op_e;

    // one entry per output port.
    typedef struct packed {
        logic [bft_pkg::LEAF_BITS-1:0] leaf;
        logic [bft_pkg::PORT_BITS-1:0] port;
    } dest_entry_t;

    // --------------------
    // receive output stage
    // --------------------
    typedef enum logic [1:0] {
        RX_EMPTY       = 2'd0,
        RX_HOLD        = 2'd1,
        RX_WAIT_CREDIT = 2'd2
    } rx_state_e;

endpackage

// ==== design/leaf_rx_router.sv ====
`timescale 1ns/1ns

module leaf_rx_router #(
    parameter int LEAF_ID       = 0,
    parameter int NUM_IN_PORTS  = 7,
    parameter int NUM_OUT_PORTS = 6
) (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  bft_pkg::bft_packet_t                      din,
    output logic [NUM_IN_PORTS-1:0]                   wr_en,
    output logic [bft_pkg::PAYLOAD_BITS-1:0]          wr_data,
    output logic [NUM_IN_PORTS-1:0]                   clr_ovf,
    output leaf_pkg::dest_entry_t [NUM_OUT_PORTS-1:0] dest_table
);

    localparam int IW = (NUM_IN_PORTS > 1) ? $clog2(NUM_IN_PORTS) : 1;
    localparam int OW = (NUM_OUT_PORTS > 1) ? $clog2(NUM_OUT_PORTS) : 1;

    bft_pkg::bft_packet_t  pkt_q;
    logic                  pkt_hit;
    leaf_pkg::cfg_op_e     op;
    leaf_pkg::dest_entry_t new_dest;
    logic [IW-1:0]         in_idx;
    logic [IW-1:0]         clr_idx;
    logic [OW-1:0]         out_idx;

    // sample every tree word, keep only those for this leaf.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pkt_hit <= 1'b0;
        end else begin
            pkt_hit <= din.vld && (din.leaf == bft_pkg::LEAF_BITS'(LEAF_ID));
        end
    end

    always_ff @(posedge clk) begin
        pkt_q <= din;
    end

    assign op            = leaf_pkg::cfg_op_e'(pkt_q.payload[bft_pkg::PAYLOAD_BITS-1 -: 2]);
    assign new_dest.leaf = pkt_q.payload[bft_pkg::PORT_BITS +: bft_pkg::LEAF_BITS];
    assign new_dest.port = pkt_q.payload[bft_pkg::PORT_BITS-1:0];
    assign wr_data       = pkt_q.payload;

    // input ports count from 1, strobe bits from 0.
    assign in_idx  = IW'(pkt_q.port - 1'b1);
    assign clr_idx = IW'(pkt_q.addr - 1'b1);
    assign out_idx = OW'(pkt_q.addr);

    always_comb begin
        wr_en   = '0;
        clr_ovf = '0;
        if (pkt_hit) begin
            if (pkt_q.port == '0) begin
                if (op == leaf_pkg::CFG_CLEAR_OVF && pkt_q.addr != '0 &&
                    int'(pkt_q.addr) <= NUM_IN_PORTS) begin
                    clr_ovf[clr_idx] = 1'b1;
                end
            end else if (int'(pkt_q.port) <= NUM_IN_PORTS) begin
                wr_en[in_idx] = 1'b1;
            end
        end
    end

    // destination table, written by CFG_SET_DEST.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dest_table <= '0;
        end else if (pkt_hit && pkt_q.port == '0 && op == leaf_pkg::CFG_SET_DEST &&
                     int'(pkt_q.addr) < NUM_OUT_PORTS) begin
            dest_table[out_idx] <= new_dest;
        end
    end

endmodule

// ==== design/leaf_rx_buffer.sv ====
`timescale 1ns/1ns

module leaf_rx_buffer #(
    parameter int RX_DEPTH     = 8,
    parameter int USER_CREDITS = 4
) (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             wr_en,
    input  logic [bft_pkg::PAYLOAD_BITS-1:0] wr_data,
    input  logic                             clr_ovf,
    output logic [bft_pkg::PAYLOAD_BITS-1:0] rx_data,
    output logic                             rx_vld,
    input  logic                             rx_credit,
    output logic                             rx_overflow
);

    localparam int AW = (RX_DEPTH > 1) ? $clog2(RX_DEPTH) : 1;
    localparam int CW = $clog2(RX_DEPTH + 1);
    localparam int KW = $clog2(USER_CREDITS + 1);

    logic [bft_pkg::PAYLOAD_BITS-1:0] mem [RX_DEPTH];
    logic [AW-1:0]                    wr_ptr;
    logic [AW-1:0]                    rd_ptr;
    logic [CW-1:0]                    count;
    logic [KW-1:0]                    credits;
    logic                             full;
    logic                             empty;
    logic                             push;
    logic                             pop;
    leaf_pkg::rx_state_e              state;
    leaf_pkg::rx_state_e              state_nxt;

    assign full  = (count == CW'(RX_DEPTH));
    assign empty = (count == '0);
    assign push  = wr_en && !full;
    // a word leaves only against a user credit.
    assign pop   = !empty && (credits != '0);

    // --------------------
    // fifo
    // --------------------
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(RX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(RX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(push) - CW'(pop);
        end
    end

    // --------------------
    // output stage
    // --------------------
    always_comb begin
        if (pop) begin
            state_nxt = leaf_pkg::RX_HOLD;
        end else if (!empty) begin
            state_nxt = leaf_pkg::RX_WAIT_CREDIT;
        end else begin
            state_nxt = leaf_pkg::RX_EMPTY;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= leaf_pkg::RX_EMPTY;
            credits     <= KW'(USER_CREDITS);
            rx_overflow <= 1'b0;
        end else begin
            state   <= state_nxt;
            credits <= credits - KW'(pop) + KW'(rx_credit);
            // a new drop wins over a clear in the same cycle.
            if (wr_en && full) begin
                rx_overflow <= 1'b1;
            end else if (clr_ovf) begin
                rx_overflow <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            rx_data <= mem[rd_ptr];
        end
    end

    assign rx_vld = (state == leaf_pkg::RX_HOLD);

endmodule

// ==== design/leaf_tx_port.sv ====
`timescale 1ns/1ns

module leaf_tx_port #(
    parameter int TX_DEPTH = 4
) (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic [bft_pkg::PAYLOAD_BITS-1:0] tx_data,
    input  logic                             tx_vld,
    input  leaf_pkg::dest_entry_t            dest,
    output logic                             req,
    output bft_pkg::bft_packet_t             pkt,
    input  logic                             grant,
    output logic                             tx_credit
);

    localparam int AW = (TX_DEPTH > 1) ? $clog2(TX_DEPTH) : 1;
    localparam int CW = $clog2(TX_DEPTH + 1);

    logic [bft_pkg::PAYLOAD_BITS-1:0] mem [TX_DEPTH];
    logic [AW-1:0]                    wr_ptr;
    logic [AW-1:0]                    rd_ptr;
    logic [CW-1:0]                    count;
    logic [bft_pkg::ADDR_BITS-1:0]    seq;
    logic                             push;
    logic                             pop;

    // the user holds credits, so a full queue should not see tx_vld.
    assign push = tx_vld && (count != CW'(TX_DEPTH));
    assign pop  = grant && req;
    assign req  = (count != '0);

    // --------------------
    // word queue
    // --------------------
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= tx_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            seq       <= '0;
            tx_credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(TX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(TX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                seq    <= seq + 1'b1;
            end
            count     <= count + CW'(push) - CW'(pop);
            tx_credit <= pop;
        end
    end

    // --------------------
    // packet build
    // --------------------
    // head word with the current destination and sequence number.
    always_comb begin
        pkt         = '0;
        pkt.vld     = 1'b1;
        pkt.leaf    = dest.leaf;
        pkt.port    = dest.port;
        pkt.addr    = seq;
        pkt.payload = mem[rd_ptr];
    end

endmodule

// ==== design/leaf_out_arbiter.sv ====
`timescale 1ns/1ns

module leaf_out_arbiter #(
    parameter int NUM_OUT_PORTS = 6
) (
    input  logic                                     clk,
    input  logic                                     arst_n,
    input  logic [NUM_OUT_PORTS-1:0]                 req,
    input  bft_pkg::bft_packet_t [NUM_OUT_PORTS-1:0] pkt_in,
    input  logic                                     resend,
    output logic [NUM_OUT_PORTS-1:0]                 grant,
    output bft_pkg::bft_packet_t                     dout
);

    localparam int IW = (NUM_OUT_PORTS > 1) ? $clog2(NUM_OUT_PORTS) : 1;

    logic [IW-1:0]        last_q;
    logic [IW-1:0]        win;
    logic                 found;
    bft_pkg::bft_packet_t dout_q;

    // search starts one past the last granted port.
    always_comb begin
        int unsigned idx;
        found = 1'b0;
        win   = '0;
        for (int k = 1; k <= NUM_OUT_PORTS; k++) begin
            idx = (int'(last_q) + k) % NUM_OUT_PORTS;
            if (!found && req[idx]) begin
                found = 1'b1;
                win   = IW'(idx);
            end
        end
        grant = '0;
        if (found && !resend) begin
            grant[win] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_q <= IW'(NUM_OUT_PORTS - 1);
            dout_q <= '0;
        end else if (grant != '0) begin
            last_q <= win;
            dout_q <= pkt_in[win];
        end else begin
            dout_q <= '0;
        end
    end

    // resend also blanks a packet registered just before it rose.
    assign dout = resend ? '0 : dout_q;

endmodule

// ==== design/leaf.sv ====
`timescale 1ns/1ns

module leaf #(
    parameter int LEAF_ID       = 0,
    parameter int NUM_IN_PORTS  = 7,
    parameter int NUM_OUT_PORTS = 6,
    parameter int RX_DEPTH      = 8,
    parameter int TX_DEPTH      = 4,
    parameter int USER_CREDITS  = 4
) (
    input  logic                                                 clk,
    input  logic                                                 arst_n,
    input  logic                                                 resend,
    input  bft_pkg::bft_packet_t                                 din_bft,
    output bft_pkg::bft_packet_t                                 dout_bft,
    output logic [NUM_IN_PORTS-1:0][bft_pkg::PAYLOAD_BITS-1:0]  rx_data,
    output logic [NUM_IN_PORTS-1:0]                              rx_vld,
    input  logic [NUM_IN_PORTS-1:0]                              rx_credit,
    output logic [NUM_IN_PORTS-1:0]                              rx_overflow,
    input  logic [NUM_OUT_PORTS-1:0][bft_pkg::PAYLOAD_BITS-1:0] tx_data,
    input  logic [NUM_OUT_PORTS-1:0]                             tx_vld,
    output logic [NUM_OUT_PORTS-1:0]                             tx_credit
);

    logic [NUM_IN_PORTS-1:0]                  wr_en;
    logic [bft_pkg::PAYLOAD_BITS-1:0]         wr_data;
    logic [NUM_IN_PORTS-1:0]                  clr_ovf;
    leaf_pkg::dest_entry_t [NUM_OUT_PORTS-1:0] dest_table;
    logic [NUM_OUT_PORTS-1:0]                 req;
    bft_pkg::bft_packet_t [NUM_OUT_PORTS-1:0] pkt;
    logic [NUM_OUT_PORTS-1:0]                 grant;

    // --------------------
    // inbound
    // --------------------
    leaf_rx_router #(
        .LEAF_ID       (LEAF_ID),
        .NUM_IN_PORTS  (NUM_IN_PORTS),
        .NUM_OUT_PORTS (NUM_OUT_PORTS)
    ) i_rx_router (
        .clk        (clk),
        .arst_n     (arst_n),
        .din        (din_bft),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .clr_ovf    (clr_ovf),
        .dest_table (dest_table)
    );

    // index i serves input port i+1.
    for (genvar i = 0; i < NUM_IN_PORTS; i++) begin : g_rx
        leaf_rx_buffer #(
            .RX_DEPTH     (RX_DEPTH),
            .USER_CREDITS (USER_CREDITS)
        ) i_rx_buffer (
            .clk         (clk),
            .arst_n      (arst_n),
            .wr_en       (wr_en[i]),
            .wr_data     (wr_data),
            .clr_ovf     (clr_ovf[i]),
            .rx_data     (rx_data[i]),
            .rx_vld      (rx_vld[i]),
            .rx_credit   (rx_credit[i]),
            .rx_overflow (rx_overflow[i])
        );
    end

    // --------------------
    // outbound
    // --------------------
    for (genvar j = 0; j < NUM_OUT_PORTS; j++) begin : g_tx
        leaf_tx_port #(
            .TX_DEPTH (TX_DEPTH)
        ) i_tx_port (
            .clk       (clk),
            .arst_n    (arst_n),
            .tx_data   (tx_data[j]),
            .tx_vld    (tx_vld[j]),
            .dest      (dest_table[j]),
            .req       (req[j]),
            .pkt       (pkt[j]),
            .grant     (grant[j]),
            .tx_credit (tx_credit[j])
        );
    end

    leaf_out_arbiter #(
        .NUM_OUT_PORTS (NUM_OUT_PORTS)
    ) i_out_arbiter (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .pkt_in (pkt),
        .resend (resend),
        .grant  (grant),
        .dout   (dout_bft)
    );

endmodule

// ==== test/leaf_tb.sv ====
`timescale 1ns/1ns

module leaf_tb;

    localparam int LEAF_ID      = 3;
    localparam int NIN          = 7;
    localparam int NOUT         = 6;
    localparam int RX_DEPTH     = 8;
    localparam int TX_DEPTH     = 4;
    localparam int USER_CREDITS = 4;
    localparam int TIMEOUT      = 2000;

    logic                                clk;
    logic                                arst_n;
    logic                                resend;
    bft_pkg::bft_packet_t                din_bft;
    bft_pkg::bft_packet_t                dout_bft;
    logic [NIN-1:0][31:0]                rx_data;
    logic [NIN-1:0]                      rx_vld;
    logic [NIN-1:0]                      rx_credit;
    logic [NIN-1:0]                      rx_overflow;
    logic [NOUT-1:0][31:0]               tx_data;
    logic [NOUT-1:0]                     tx_vld;
    logic [NOUT-1:0]                     tx_credit;

    // scoreboards and user model state.
    logic [31:0]          exp_rx [NIN][$];
    bft_pkg::bft_packet_t exp_tx [NOUT][$];
    int                   rx_received [NIN] = '{default: 0};
    int                   rx_returned [NIN] = '{default: 0};
    int                   tx_sent [NOUT] = '{default: 0};
    int                   tx_returned [NOUT] = '{default: 0};
    logic [4:0]           dest_leaf [NOUT] = '{default: 0};
    logic [3:0]           dest_port [NOUT] = '{default: 0};
    logic [6:0]           exp_seq [NOUT] = '{default: 0};
    logic                 rx_hold = 1'b0;
    logic [NIN-1:0]       ovf_allowed = '0;
    logic                 rr_check = 1'b0;

    leaf #(
        .LEAF_ID       (LEAF_ID),
        .NUM_IN_PORTS  (NIN),
        .NUM_OUT_PORTS (NOUT),
        .RX_DEPTH      (RX_DEPTH),
        .TX_DEPTH      (TX_DEPTH),
        .USER_CREDITS  (USER_CREDITS)
    ) i_leaf (
        .clk         (clk),
        .arst_n      (arst_n),
        .resend      (resend),
        .din_bft     (din_bft),
        .dout_bft    (dout_bft),
        .rx_data     (rx_data),
        .rx_vld      (rx_vld),
        .rx_credit   (rx_credit),
        .rx_overflow (rx_overflow),
        .tx_data     (tx_data),
        .tx_vld      (tx_vld),
        .tx_credit   (tx_credit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    // --------------------
    // user receive model
    // --------------------
    // credits go back after a random delay unless held.
    initial begin
        rx_credit = '0;
        forever begin
            @(posedge clk);
            #1;
            rx_credit = '0;
            for (int p = 0; p < NIN; p++) begin
                if (!rx_hold && rx_received[p] > rx_returned[p] && ($urandom % 4) == 0) begin
                    rx_credit[p]   = 1'b1;
                    rx_returned[p] = rx_returned[p] + 1;
                end
            end
        end
    end

    // --------------------
    // monitors
    // --------------------
    always @(negedge clk) begin : monitor
        int   src;
        logic want;
        logic resend_q;
        int   rr_prev;
        if (!arst_n) begin
            resend_q = 1'b0;
            rr_prev  = -1;
        end else begin
            for (int p = 0; p < NIN; p++) begin
                if (rx_vld[p]) begin
                    assert (exp_rx[p].size() > 0)
                    else fail_now($sformatf("word on rx port %0d at %0t was never sent", p + 1, $time));
                    assert (rx_data[p] == exp_rx[p][0])
                    else fail_now($sformatf("** Error: time %0t: rx_data[%0d] expected %h actual %h",
                                            $time, p + 1, exp_rx[p][0], rx_data[p]));
                    assert (rx_received[p] < USER_CREDITS + rx_returned[p])
                    else fail_now($sformatf("rx port %0d delivered more words than credits", p + 1));
                    void'(exp_rx[p].pop_front());
                    rx_received[p] = rx_received[p] + 1;
                end
            end
            assert ((rx_overflow & ~ovf_allowed) == '0)
            else fail_now($sformatf("** Error: time %0t: rx_overflow expected %b actual %b",
                                    $time, rx_overflow & ovf_allowed, rx_overflow));
            if (resend) begin
                assert (dout_bft == '0)
                else fail_now($sformatf("** Error: time %0t: dout_bft expected %h actual %h",
                                        $time, 49'h0, dout_bft));
            end
            if (resend && resend_q) begin
                assert (tx_credit == '0)
                else fail_now($sformatf("** Error: time %0t: tx_credit expected %b actual %b",
                                        $time, 6'b0, tx_credit));
            end
            for (int j = 0; j < NOUT; j++) begin
                want = dout_bft.vld && (dout_bft.leaf == dest_leaf[j]);
                if (!resend) begin
                    assert (tx_credit[j] == want)
                    else fail_now($sformatf("** Error: time %0t: tx_credit[%0d] expected %b actual %b",
                                            $time, j, want, tx_credit[j]));
                end
                if (tx_credit[j]) begin
                    tx_returned[j] = tx_returned[j] + 1;
                end
            end
            if (dout_bft.vld) begin
                src = -1;
                for (int j = 0; j < NOUT; j++) begin
                    if (dout_bft.leaf == dest_leaf[j]) begin
                        src = j;
                    end
                end
                assert (src >= 0 && exp_tx[src].size() > 0)
                else fail_now($sformatf("packet on dout_bft at %0t was never sent", $time));
                assert (dout_bft == exp_tx[src][0])
                else fail_now($sformatf("** Error: time %0t: dout_bft expected %h actual %h",
                                        $time, exp_tx[src][0], dout_bft));
                void'(exp_tx[src].pop_front());
                if (rr_check && rr_prev >= 0) begin
                    assert (src == (rr_prev + 1) % NOUT)
                    else fail_now($sformatf("grant went to port %0d after port %0d", src, rr_prev));
                end
                rr_prev = src;
            end
            if (!rr_check) begin
                rr_prev = -1;
            end
            resend_q = resend;
        end
    end

    // --------------------
    // stimulus tasks
    // --------------------
    task automatic tree_send(input logic [4:0] leaf, input logic [3:0] port,
                             input logic [6:0] addr, input logic [31:0] payload);
        din_bft.vld     = 1'b1;
        din_bft.leaf    = leaf;
        din_bft.port    = port;
        din_bft.addr    = addr;
        din_bft.payload = payload;
        @(posedge clk);
        #1;
        din_bft = '0;
    endtask

    function automatic logic tx_ready(input logic [NOUT-1:0] mask);
        logic ok;
        ok = 1'b1;
        for (int j = 0; j < NOUT; j++) begin
            if (mask[j] && (TX_DEPTH - tx_sent[j] + tx_returned[j]) <= 0) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // one word on each selected port in the same cycle.
    task automatic tx_send_mask(input logic [NOUT-1:0] mask);
        int                   waited;
        bft_pkg::bft_packet_t e;
        waited = 0;
        while (!tx_ready(mask)) begin
            if (waited >= TIMEOUT) begin
                fail_now("timed out waiting for a tx credit");
            end
            @(posedge clk);
            #1;
            waited++;
        end
        for (int j = 0; j < NOUT; j++) begin
            if (mask[j]) begin
                tx_data[j] = $urandom;
                tx_vld[j]  = 1'b1;
                e.vld      = 1'b1;
                e.leaf     = dest_leaf[j];
                e.port     = dest_port[j];
                e.addr     = exp_seq[j];
                e.payload  = tx_data[j];
                exp_tx[j].push_back(e);
                exp_seq[j] = exp_seq[j] + 1'b1;
                tx_sent[j] = tx_sent[j] + 1;
            end
        end
        @(posedge clk);
        #1;
        tx_vld = '0;
    endtask

    function automatic logic all_drained();
        logic done;
        done = 1'b1;
        for (int p = 0; p < NIN; p++) begin
            if (exp_rx[p].size() != 0 || rx_received[p] != rx_returned[p]) begin
                done = 1'b0;
            end
        end
        for (int j = 0; j < NOUT; j++) begin
            if (exp_tx[j].size() != 0 || tx_sent[j] != tx_returned[j]) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (!all_drained()) begin
            if (waited >= TIMEOUT) begin
                fail_now("timed out waiting for the scoreboards to drain");
            end
            @(posedge clk);
            #1;
            waited++;
        end
    endtask

    task automatic wait_overflow(input int p, input logic level);
        int waited;
        waited = 0;
        while (rx_overflow[p-1] !== level) begin
            if (waited >= TIMEOUT) begin
                fail_now($sformatf("timed out waiting for rx_overflow[%0d] = %b", p, level));
            end
            @(posedge clk);
            #1;
            waited++;
        end
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        int          p;
        int          r;
        logic [31:0] w;
        void'($urandom(49189));
        arst_n  = 1'b0;
        resend  = 1'b0;
        din_bft = '0;
        tx_data = '0;
        tx_vld  = '0;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;

        @(negedge clk);
        assert (rx_vld == '0)
        else fail_now($sformatf("** Error: time %0t: rx_vld expected %b actual %b",
                                $time, 7'b0, rx_vld));
        assert (rx_overflow == '0)
        else fail_now($sformatf("** Error: time %0t: rx_overflow expected %b actual %b",
                                $time, 7'b0, rx_overflow));
        assert (tx_credit == '0)
        else fail_now($sformatf("** Error: time %0t: tx_credit expected %b actual %b",
                                $time, 6'b0, tx_credit));
        assert (dout_bft == '0)
        else fail_now($sformatf("** Error: time %0t: dout_bft expected %h actual %h",
                                $time, 49'h0, dout_bft));
        @(posedge clk);
        #1;

        // inbound delivery with filtering.
        for (int n = 0; n < 60; n++) begin
            r = $urandom % 4;
            w = $urandom;
            if (r == 0) begin
                tree_send(5'((LEAF_ID + 1 + ($urandom % 31)) % 32), 4'(1 + $urandom % 15), 7'd0, w);
            end else if (r == 1) begin
                tree_send(5'(LEAF_ID), 4'(NIN + 1 + $urandom % (15 - NIN)), 7'd0, w);
            end else begin
                p = 1 + $urandom % NIN;
                exp_rx[p-1].push_back(w);
                tree_send(5'(LEAF_ID), 4'(p), 7'd0, w);
            end
        end
        wait_drained();

        // overflow on one port with credits withheld.
        p           = 1 + $urandom % NIN;
        rx_hold     = 1'b1;
        ovf_allowed = NIN'(1) << (p - 1);
        for (int n = 0; n < RX_DEPTH + USER_CREDITS + 2; n++) begin
            w = $urandom;
            if (n < RX_DEPTH + USER_CREDITS) begin
                exp_rx[p-1].push_back(w);
            end
            tree_send(5'(LEAF_ID), 4'(p), 7'd0, w);
        end
        wait_overflow(p, 1'b1);
        rx_hold = 1'b0;
        tree_send(5'(LEAF_ID), 4'd0, 7'(p), {leaf_pkg::CFG_CLEAR_OVF, 30'd0});
        wait_overflow(p, 1'b0);
        ovf_allowed = '0;
        wait_drained();

        // outbound with configured destinations.
        for (int j = 0; j < NOUT; j++) begin
            dest_leaf[j] = 5'(8 + j);
            dest_port[j] = 4'($urandom % 16);
            tree_send(5'(LEAF_ID), 4'd0, 7'(j),
                      {leaf_pkg::CFG_SET_DEST, 21'd0, dest_leaf[j], dest_port[j]});
        end
        @(posedge clk);
        #1;
        for (int n = 0; n < 30; n++) begin
            tx_send_mask(NOUT'(1) << ($urandom % NOUT));
        end
        wait_drained();

        // backlog every port under resend, then check round robin.
        resend = 1'b1;
        for (int n = 0; n < TX_DEPTH; n++) begin
            tx_send_mask('1);
        end
        repeat (5) @(posedge clk);
        #1;
        rr_check = 1'b1;
        resend   = 1'b0;
        wait_drained();
        rr_check = 1'b0;

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== files.f ====
design/bft_pkg.sv
design/leaf_pkg.sv
design/leaf_rx_router.sv
design/leaf_rx_buffer.sv
design/leaf_tx_port.sv
design/leaf_out_arbiter.sv
design/leaf.sv
test/leaf_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= files.f
TB_TOP    ?= leaf_tb
RTL_TOP   ?= leaf
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Some tests failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "All tests passed" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only design/bft_pkg.sv design/leaf_pkg.sv design/leaf_rx_router.sv \
		design/leaf_rx_buffer.sv design/leaf_tx_port.sv design/leaf_out_arbiter.sv \
		design/leaf.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
